// File: Makefile
# Verilator build and run of the sprint core testbench

VERILATOR ?= verilator
TOP       ?= sprint_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail, not the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/sprint_checks.svh
// sprint core testbench checks
// typed compares of board rows, line count, screen state and time digits
`ifndef SPRINT_CHECKS_SVH
`define SPRINT_CHECKS_SVH

task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at %0t", $time);
endtask

task automatic report_failure(input string why);
    $display("error at %0t: %s", $time, why);
    err_count++;
    stop_run();
endtask

task automatic check_row(input int row, input logic [PLAYFIELD_COLS-1:0][TILE_W-1:0] got,
                         input logic [PLAYFIELD_COLS-1:0][TILE_W-1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t row_cells[%0d]: got %h expected %h", $time, row, got, exp);
        err_count++;
        stop_run();
    end
endtask

task automatic check_lines(input logic [LINES_W-1:0] got, input logic [LINES_W-1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t lines_cleared: got %0d expected %0d", $time, got, exp);
        err_count++;
        stop_run();
    end
endtask

task automatic check_screen(input logic [SCREEN_W-1:0] got, input logic got_running,
                            input logic [SCREEN_W-1:0] exp);
    logic exp_running;
    // running is high exactly while a sprint is on
    exp_running = (exp == SCREEN_SPRINT);
    if (got !== exp) begin
        $display("[FAIL] t=%0t screen: got %0d expected %0d", $time, got, exp);
        err_count++;
        stop_run();
    end
    if (got_running !== exp_running) begin
        $display("[FAIL] t=%0t running: got %b expected %b", $time, got_running, exp_running);
        err_count++;
        stop_run();
    end
endtask

task automatic compare_time_field(input string name, input int unsigned got,
                                  input int unsigned exp);
    if (got != exp) begin
        $display("[FAIL] t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        err_count++;
        stop_run();
    end
endtask

task automatic check_time(input logic [DIGIT_W-1:0] ms, input logic [DIGIT_W-1:0] cs,
                          input logic [DIGIT_W-1:0] ds, input logic [SEXA_W-1:0] s,
                          input logic [SEXA_W-1:0] mn, input logic [HOURS_W-1:0] h,
                          input int unsigned total_ms);
    compare_time_field("time_ms", ms, total_ms % 10);
    compare_time_field("time_cs", cs, (total_ms / 10) % 10);
    compare_time_field("time_ds", ds, (total_ms / 100) % 10);
    compare_time_field("time_s", s, (total_ms / 1000) % 60);
    compare_time_field("time_min", mn, (total_ms / 60000) % 60);
    compare_time_field("time_h", h, (total_ms / 3600000) % (1 << HOURS_W));
endtask

`endif

// File: dv/sprint_core_tb.sv
// sprint core testbench
// table of starts, locks and waits checked against a board and timer model
`timescale 1ns/100ps
`default_nettype none

module sprint_core_tb;
    import tetris_pkg::*;
    import timer_pkg::*;

    localparam int LINES_GOAL   = 3;
    localparam int TICKS_PER_MS = 4;
    localparam int SETTLE       = PLAYFIELD_ROWS + 4;

    typedef enum logic [1:0] {K_START, K_LOCK, K_IDLE} kind_t;
    typedef logic [PLAYFIELD_COLS-1:0][TILE_W-1:0] row_t;
    typedef logic [PIECE_TILES-1:0][ROW_W-1:0]     rows_t;
    typedef logic [PIECE_TILES-1:0][COL_W-1:0]     cols_t;
    typedef struct packed {
        kind_t               kind;
        logic [TILE_W-1:0]   ptype;
        rows_t               rows;
        cols_t               cols;
        int                  idle;
        logic [LINES_W-1:0]  exp_lines;
        logic [SCREEN_W-1:0] exp_screen;
    } step_t;

    logic                clk;
    logic                arst_n;
    logic                start;
    logic                lock;
    logic [TILE_W-1:0]   lock_type;
    rows_t               lock_rows;
    cols_t               lock_cols;
    logic [ROW_W-1:0]    read_row;
    row_t                row_cells;
    logic [LINES_W-1:0]  lines_cleared;
    logic [SCREEN_W-1:0] screen;
    logic                running;
    logic [DIGIT_W-1:0]  time_ms;
    logic [DIGIT_W-1:0]  time_cs;
    logic [DIGIT_W-1:0]  time_ds;
    logic [SEXA_W-1:0]   time_s;
    logic [SEXA_W-1:0]   time_min;
    logic [HOURS_W-1:0]  time_h;

    step_t               steps[$];
    row_t                model_board [PLAYFIELD_ROWS];
    logic [SCREEN_W-1:0] model_screen;
    int                  model_lines;
    int unsigned         run_edges = 0;
    int                  seed;
    int                  err_count = 0;

    `include "sprint_checks.svh"

    sprint_core #(
        .LINES_GOAL   (LINES_GOAL),
        .TICKS_PER_MS (TICKS_PER_MS)
    ) sprint_core_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sampled edges with the sprint running, restarted by an accepted start
    always @(posedge clk) begin
        if (start && !running) begin
            run_edges = 0;
        end else if (running) begin
            run_edges++;
        end
    end

    function automatic int count_blank(input row_t row);
        int n;
        n = 0;
        for (int c = 0; c < PLAYFIELD_COLS; c++) begin
            if (row[c] == TILE_BLANK) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic model_lock(input logic [TILE_W-1:0] ptype, input rows_t rows,
                              input cols_t cols);
        row_t kept [PLAYFIELD_ROWS];
        int   w;
        w    = PLAYFIELD_ROWS - 1;
        kept = '{default: '0};
        if (model_screen == SCREEN_SPRINT) begin
            for (int t = 0; t < PIECE_TILES; t++) begin
                model_board[rows[t]][cols[t]] = ptype;
            end
            // full rows vanish, the rest sink to the bottom in order
            for (int r = PLAYFIELD_ROWS - 1; r >= 0; r--) begin
                if (count_blank(model_board[r]) == 0) begin
                    model_lines++;
                end else if (count_blank(model_board[r]) < PLAYFIELD_COLS) begin
                    kept[w] = model_board[r];
                    w--;
                end
            end
            model_board = kept;
            if (model_lines >= LINES_GOAL) begin
                model_screen = SCREEN_DONE;
            end
        end
    endtask

    task automatic add_step(input kind_t kind, input int idle, input int lines,
                            input logic [SCREEN_W-1:0] scr);
        step_t s;
        s            = '0;
        s.kind       = kind;
        s.idle       = idle;
        s.exp_lines  = LINES_W'(lines);
        s.exp_screen = scr;
        steps.push_back(s);
    endtask

    // a blank type asks for a random piece
    task automatic add_lock(input logic [TILE_W-1:0] ptype, input int r0, c0, r1, c1,
                            input int r2, c2, r3, c3, lines, input logic [SCREEN_W-1:0] scr);
        step_t s;
        s            = '0;
        s.kind       = K_LOCK;
        s.ptype      = ptype;
        s.rows       = {ROW_W'(r3), ROW_W'(r2), ROW_W'(r1), ROW_W'(r0)};
        s.cols       = {COL_W'(c3), COL_W'(c2), COL_W'(c1), COL_W'(c0)};
        s.exp_lines  = LINES_W'(lines);
        s.exp_screen = scr;
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step(K_IDLE, 4, 0, SCREEN_IDLE);
        add_lock(TILE_I, 19, 0, 19, 1, 19, 2, 19, 3, 0, SCREEN_IDLE);
        add_step(K_START, 0, 0, SCREEN_SPRINT);
        add_lock(TILE_I, 19, 0, 19, 1, 19, 2, 19, 3, 0, SCREEN_SPRINT);
        add_lock(TILE_BLANK, 18, 4, 18, 5, 19, 4, 19, 5, 0, SCREEN_SPRINT);
        add_lock(TILE_BLANK, 18, 6, 19, 6, 19, 7, 19, 8, 0, SCREEN_SPRINT);
        // bottom row completes
        add_lock(TILE_I, 16, 9, 17, 9, 18, 9, 19, 9, 1, SCREEN_SPRINT);
        add_lock(TILE_I, 19, 0, 19, 1, 19, 2, 19, 3, 1, SCREEN_SPRINT);
        add_lock(TILE_BLANK, 18, 0, 18, 1, 18, 2, 18, 3, 1, SCREEN_SPRINT);
        add_lock(TILE_BLANK, 18, 4, 18, 5, 18, 6, 18, 7, 1, SCREEN_SPRINT);
        // two rows at once reach the goal
        add_lock(TILE_J, 17, 8, 18, 8, 19, 8, 19, 7, 3, SCREEN_DONE);
        add_lock(TILE_T, 15, 0, 15, 1, 15, 2, 14, 1, 3, SCREEN_DONE);
        add_step(K_IDLE, 50, 3, SCREEN_DONE);
        add_step(K_START, 0, 0, SCREEN_SPRINT);
        add_lock(TILE_BLANK, 19, 3, 19, 4, 19, 5, 19, 6, 0, SCREEN_SPRINT);
        add_step(K_IDLE, 70000, 0, SCREEN_SPRINT);
    endtask

    task automatic check_board();
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            @(posedge clk);
            #1;
            read_row = ROW_W'(r);
            #1;
            check_row(r, row_cells, model_board[r]);
        end
    endtask

    task automatic apply_step(input step_t s);
        logic [TILE_W-1:0] ptype;
        int                waited;
        ptype  = s.ptype;
        waited = 0;
        if (ptype == TILE_BLANK) begin
            ptype = TILE_W'(($unsigned($random(seed)) % 7) + 1);
        end
        @(posedge clk);
        #1;
        case (s.kind)
            K_START: begin
                start = 1'b1;
                @(posedge clk);
                #1;
                start        = 1'b0;
                model_board  = '{default: '0};
                model_lines  = 0;
                model_screen = SCREEN_SPRINT;
                while (screen != SCREEN_SPRINT) begin
                    if (waited == 8) begin
                        report_failure("screen did not enter sprint after start");
                    end
                    @(posedge clk);
                    #1;
                    waited++;
                end
                check_lines(lines_cleared, '0);
                check_time(time_ms, time_cs, time_ds, time_s, time_min, time_h, 0);
            end
            K_LOCK: begin
                lock      = 1'b1;
                lock_type = ptype;
                lock_rows = s.rows;
                lock_cols = s.cols;
                @(posedge clk);
                #1;
                lock = 1'b0;
                model_lock(ptype, s.rows, s.cols);
            end
            default: begin
                repeat (s.idle) @(posedge clk);
            end
        endcase
        repeat (SETTLE) @(posedge clk);
        check_board();
        check_lines(lines_cleared, s.exp_lines);
        check_screen(screen, running, s.exp_screen);
        check_time(time_ms, time_cs, time_ds, time_s, time_min, time_h,
                   run_edges / TICKS_PER_MS);
    endtask

    initial begin
        arst_n       = 1'b0;
        start        = 1'b0;
        lock         = 1'b0;
        lock_type    = TILE_BLANK;
        lock_rows    = '0;
        lock_cols    = '0;
        read_row     = '0;
        seed         = 8;
        model_board  = '{default: '0};
        model_lines  = 0;
        model_screen = SCREEN_IDLE;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure("checks failed during the stimulus table");
        end
    end

    // budget per step covers the settle wait, the row reads and the start handshake
    initial begin
        int unsigned limit;
        #1;
        limit = 16 + 8;
        foreach (steps[i]) begin
            limit += 3 * PLAYFIELD_ROWS + steps[i].idle;
        end
        repeat (limit) @(posedge clk);
        report_failure("watchdog timeout, the stimulus table did not finish");
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+dv
logic/tetris_pkg.sv
logic/timer_pkg.sv
logic/lock_if.sv
logic/game_ctrl.sv
logic/playfield_store.sv
logic/line_tally.sv
logic/sprint_timer.sv
logic/sprint_core.sv
dv/sprint_core_tb.sv

// File: logic/game_ctrl.sv
// sprint screen control
// starts and ends a sprint, gates piece locks onto the lock bus
`timescale 1ns/100ps
`default_nettype none

module game_ctrl #(
    parameter int unsigned LINES_GOAL = 40
) (
    input  logic                                                    clk,
    input  logic                                                    arst_n,
    input  logic                                                    start,
    input  logic                                                    lock,
    input  logic [tetris_pkg::TILE_W-1:0]                           lock_type,
    input  logic [tetris_pkg::PIECE_TILES-1:0][tetris_pkg::ROW_W-1:0] lock_rows,
    input  logic [tetris_pkg::PIECE_TILES-1:0][tetris_pkg::COL_W-1:0] lock_cols,
    input  logic [tetris_pkg::LINES_W-1:0]                          lines_cleared,
    output logic [tetris_pkg::SCREEN_W-1:0]                         screen,
    output logic                                                    running,
    output logic                                                    game_start,
    lock_if.ctrl                                                    lock_bus
);
    import tetris_pkg::*;

    localparam logic [LINES_W-1:0] GOAL = LINES_W'(LINES_GOAL);

    logic start_ok;
    logic lock_ok;

    // a start while the clear is pending is not taken twice
    assign start_ok = start && !game_start &&
                      (screen == SCREEN_IDLE || screen == SCREEN_DONE);
    assign lock_ok  = lock && (screen == SCREEN_SPRINT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            screen <= SCREEN_IDLE;
        end else begin
            case (screen)
                SCREEN_IDLE, SCREEN_DONE: begin
                    if (game_start) begin
                        screen <= SCREEN_SPRINT;
                    end
                end
                SCREEN_SPRINT: begin
                    if (lines_cleared >= GOAL) begin
                        screen <= SCREEN_DONE;
                    end
                end
                default: screen <= SCREEN_IDLE;
            endcase
        end
    end

    assign running = (screen == SCREEN_SPRINT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            game_start          <= 1'b0;
            lock_bus.lock_valid <= 1'b0;
        end else begin
            game_start          <= start_ok;
            lock_bus.lock_valid <= lock_ok;
        end
    end

    // the board is wiped in the same cycle as the rest of the game state
    assign lock_bus.clear_board = game_start;

    always_ff @(posedge clk) begin
        if (lock_ok) begin
            lock_bus.piece_type <= lock_type;
            lock_bus.tile_rows  <= lock_rows;
            lock_bus.tile_cols  <= lock_cols;
        end
    end

    a_no_lock_on_clear: assert property (@(posedge clk) disable iff (!arst_n)
        !(lock_bus.lock_valid && lock_bus.clear_board));

endmodule

`default_nettype wire

// File: logic/line_tally.sv
// lines cleared tally
// accumulates the number of full rows seen each cycle
`timescale 1ns/100ps
`default_nettype none

module line_tally (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  game_start,
    input  logic [tetris_pkg::PLAYFIELD_ROWS-1:0] lines_full,
    output logic [tetris_pkg::LINES_W-1:0]        lines_cleared
);
    import tetris_pkg::*;

    logic [LINES_W-1:0] full_count;

    always_comb begin
        full_count = '0;
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            full_count = full_count + LINES_W'(lines_full[r]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lines_cleared <= '0;
        end else if (game_start) begin
            lines_cleared <= '0;
        end else begin
            lines_cleared <= lines_cleared + full_count;
        end
    end

    a_tally_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
        !game_start |=> lines_cleared >= $past(lines_cleared));

endmodule

`default_nettype wire

// File: logic/lock_if.sv
// piece lock bus
// carries an accepted lock and the board clear from control to the board store
`timescale 1ns/100ps
`default_nettype none

interface lock_if;
    import tetris_pkg::*;

    logic                              clear_board;
    logic                              lock_valid;
    logic [TILE_W-1:0]                 piece_type;
    logic [PIECE_TILES-1:0][ROW_W-1:0] tile_rows;
    logic [PIECE_TILES-1:0][COL_W-1:0] tile_cols;

    modport ctrl (
        output clear_board,
        output lock_valid,
        output piece_type,
        output tile_rows,
        output tile_cols
    );

    modport store (
        input clear_board,
        input lock_valid,
        input piece_type,
        input tile_rows,
        input tile_cols
    );

endinterface

`default_nettype wire

// File: logic/playfield_store.sv
// playfield store
// locked board with full and empty line detection, line clear and row collapse
`timescale 1ns/100ps
`default_nettype none

module playfield_store (
    input  logic                                                          clk,
    input  logic                                                          arst_n,
    lock_if.store                                                         lock_bus,
    input  logic [tetris_pkg::ROW_W-1:0]                                  read_row,
    output logic [tetris_pkg::PLAYFIELD_COLS-1:0][tetris_pkg::TILE_W-1:0] row_cells,
    output logic [tetris_pkg::PLAYFIELD_ROWS-1:0]                         lines_full
);
    import tetris_pkg::*;

    localparam int COL_IDX_W = $clog2(PLAYFIELD_COLS);
    localparam logic [PLAYFIELD_COLS-1:0][TILE_W-1:0] BLANK_ROW =
        {PLAYFIELD_COLS{TILE_BLANK}};

    logic [PLAYFIELD_COLS-1:0][TILE_W-1:0] board      [PLAYFIELD_ROWS];
    logic [PLAYFIELD_COLS-1:0][TILE_W-1:0] survivor   [PLAYFIELD_ROWS];
    logic [PLAYFIELD_COLS-1:0][TILE_W-1:0] board_next [PLAYFIELD_ROWS];
    logic [PLAYFIELD_ROWS-1:0]             lines_empty;
    logic [PLAYFIELD_ROWS-1:0]             taken;

    always_comb begin
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            lines_full[r]  = 1'b1;
            lines_empty[r] = 1'b1;
            for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                if (board[r][c] == TILE_BLANK) begin
                    lines_full[r] = 1'b0;
                end else begin
                    lines_empty[r] = 1'b0;
                end
            end
        end
    end

    // bit r set when the row below r pulls it down
    assign taken = lines_empty >> 1;

    // full rows never move, they only blank
    always_comb begin
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            survivor[r] = lines_full[r] ? BLANK_ROW : board[r];
        end
        board_next[0] = (lines_empty[0] || taken[0]) ? BLANK_ROW : survivor[0];
        for (int r = 1; r < PLAYFIELD_ROWS; r++) begin
            if (lines_empty[r]) begin
                board_next[r] = survivor[r-1];
            end else if (taken[r]) begin
                board_next[r] = BLANK_ROW;
            end else begin
                board_next[r] = survivor[r];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                board[r] <= BLANK_ROW;
            end
        end else if (lock_bus.clear_board) begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                board[r] <= BLANK_ROW;
            end
        end else begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                board[r] <= board_next[r];
            end
            // lock tiles land on top of the collapse result
            if (lock_bus.lock_valid) begin
                for (int t = 0; t < PIECE_TILES; t++) begin
                    board[lock_bus.tile_rows[t]][lock_bus.tile_cols[t][COL_IDX_W-1:0]] <=
                        lock_bus.piece_type;
                end
            end
        end
    end

    assign row_cells = (read_row < ROW_W'(PLAYFIELD_ROWS)) ? board[read_row] : BLANK_ROW;

    for (genvar t = 0; t < PIECE_TILES; t++) begin : g_tile_chk
        a_tile_in_board: assert property (@(posedge clk) disable iff (!arst_n)
            lock_bus.lock_valid |->
                (lock_bus.tile_rows[t] < ROW_W'(PLAYFIELD_ROWS)) &&
                (lock_bus.tile_cols[t] < COL_W'(PLAYFIELD_COLS)));
    end

endmodule

`default_nettype wire

// File: logic/sprint_core.sv
// sprint core top
// game control, playfield store, line tally and sprint timer
`timescale 1ns/100ps
`default_nettype none

module sprint_core #(
    parameter int unsigned LINES_GOAL   = 40,
    parameter int unsigned TICKS_PER_MS = 50000
) (
    input  logic                                                          clk,
    input  logic                                                          arst_n,
    input  logic                                                          start,
    input  logic                                                          lock,
    input  logic [tetris_pkg::TILE_W-1:0]                                 lock_type,
    input  logic [tetris_pkg::PIECE_TILES-1:0][tetris_pkg::ROW_W-1:0]     lock_rows,
    input  logic [tetris_pkg::PIECE_TILES-1:0][tetris_pkg::COL_W-1:0]     lock_cols,
    input  logic [tetris_pkg::ROW_W-1:0]                                  read_row,
    output logic [tetris_pkg::PLAYFIELD_COLS-1:0][tetris_pkg::TILE_W-1:0] row_cells,
    output logic [tetris_pkg::LINES_W-1:0]                                lines_cleared,
    output logic [tetris_pkg::SCREEN_W-1:0]                               screen,
    output logic                                                          running,
    output logic [timer_pkg::DIGIT_W-1:0]                                 time_ms,
    output logic [timer_pkg::DIGIT_W-1:0]                                 time_cs,
    output logic [timer_pkg::DIGIT_W-1:0]                                 time_ds,
    output logic [timer_pkg::SEXA_W-1:0]                                  time_s,
    output logic [timer_pkg::SEXA_W-1:0]                                  time_min,
    output logic [timer_pkg::HOURS_W-1:0]                                 time_h
);
    import tetris_pkg::*;

    logic                      game_start;
    logic [PLAYFIELD_ROWS-1:0] lines_full;

    lock_if lock_bus ();

    game_ctrl #(
        .LINES_GOAL    (LINES_GOAL)
    ) game_ctrl_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (start),
        .lock          (lock),
        .lock_type     (lock_type),
        .lock_rows     (lock_rows),
        .lock_cols     (lock_cols),
        .lines_cleared (lines_cleared),
        .screen        (screen),
        .running       (running),
        .game_start    (game_start),
        .lock_bus      (lock_bus)
    );

    playfield_store playfield_store_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .lock_bus      (lock_bus),
        .read_row      (read_row),
        .row_cells     (row_cells),
        .lines_full    (lines_full)
    );

    line_tally line_tally_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .game_start    (game_start),
        .lines_full    (lines_full),
        .lines_cleared (lines_cleared)
    );

    sprint_timer #(
        .TICKS_PER_MS  (TICKS_PER_MS)
    ) sprint_timer_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .running       (running),
        .game_start    (game_start),
        .time_ms       (time_ms),
        .time_cs       (time_cs),
        .time_ds       (time_ds),
        .time_s        (time_s),
        .time_min      (time_min),
        .time_h        (time_h)
    );

endmodule

`default_nettype wire

// File: logic/sprint_timer.sv
// sprint timer
// millisecond prescaler feeding cascaded ms, cs, ds, s, min and h counters
`timescale 1ns/100ps
`default_nettype none

module sprint_timer #(
    parameter int unsigned TICKS_PER_MS = 50000
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           running,
    input  logic                           game_start,
    output logic [timer_pkg::DIGIT_W-1:0]  time_ms,
    output logic [timer_pkg::DIGIT_W-1:0]  time_cs,
    output logic [timer_pkg::DIGIT_W-1:0]  time_ds,
    output logic [timer_pkg::SEXA_W-1:0]   time_s,
    output logic [timer_pkg::SEXA_W-1:0]   time_min,
    output logic [timer_pkg::HOURS_W-1:0]  time_h
);
    import timer_pkg::*;

    localparam int PRE_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_MS - 1);

    logic [PRE_W-1:0] prescale;
    logic             ms_tick;
    logic             ms_wrap;
    logic             cs_wrap;
    logic             ds_wrap;
    logic             s_wrap;
    logic             min_wrap;

    // carry chain
    assign ms_tick  = running && (prescale == PRE_LAST);
    assign ms_wrap  = ms_tick && (time_ms == DIGIT_MAX);
    assign cs_wrap  = ms_wrap && (time_cs == DIGIT_MAX);
    assign ds_wrap  = cs_wrap && (time_ds == DIGIT_MAX);
    assign s_wrap   = ds_wrap && (time_s == SEXA_MAX);
    assign min_wrap = s_wrap && (time_min == SEXA_MAX);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale <= '0;
            time_ms  <= '0;
            time_cs  <= '0;
            time_ds  <= '0;
            time_s   <= '0;
            time_min <= '0;
            time_h   <= '0;
        end else if (game_start) begin
            prescale <= '0;
            time_ms  <= '0;
            time_cs  <= '0;
            time_ds  <= '0;
            time_s   <= '0;
            time_min <= '0;
            time_h   <= '0;
        end else begin
            if (running) begin
                prescale <= (prescale == PRE_LAST) ? '0 : prescale + 1'b1;
            end
            if (ms_tick) begin
                time_ms <= ms_wrap ? '0 : time_ms + 1'b1;
            end
            if (ms_wrap) begin
                time_cs <= cs_wrap ? '0 : time_cs + 1'b1;
            end
            if (cs_wrap) begin
                time_ds <= ds_wrap ? '0 : time_ds + 1'b1;
            end
            if (ds_wrap) begin
                time_s <= s_wrap ? '0 : time_s + 1'b1;
            end
            if (s_wrap) begin
                time_min <= min_wrap ? '0 : time_min + 1'b1;
            end
            // hours wrap at their width
            if (min_wrap) begin
                time_h <= time_h + 1'b1;
            end
        end
    end

    a_digits_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        (time_ms <= DIGIT_MAX) && (time_cs <= DIGIT_MAX) && (time_ds <= DIGIT_MAX) &&
        (time_s <= SEXA_MAX) && (time_min <= SEXA_MAX));

endmodule

`default_nettype wire

// File: logic/tetris_pkg.sv
// tetris playfield package
// board geometry, tile codes, line goal width and screen state codes
`default_nettype none

package tetris_pkg;

    // board geometry, row 0 is the top
    parameter int PLAYFIELD_ROWS = 20;
    parameter int PLAYFIELD_COLS = 10;
    parameter int ROW_W          = 5;
    parameter int COL_W          = 5;

    // tile codes
    parameter int TILE_W = 3;
    parameter logic [TILE_W-1:0] TILE_BLANK = 3'd0;
    parameter logic [TILE_W-1:0] TILE_I     = 3'd1;
    parameter logic [TILE_W-1:0] TILE_O     = 3'd2;
    parameter logic [TILE_W-1:0] TILE_T     = 3'd3;
    parameter logic [TILE_W-1:0] TILE_J     = 3'd4;
    parameter logic [TILE_W-1:0] TILE_L     = 3'd5;
    parameter logic [TILE_W-1:0] TILE_S     = 3'd6;
    parameter logic [TILE_W-1:0] TILE_Z     = 3'd7;

    parameter int PIECE_TILES = 4;

    // lines cleared counter width
    parameter int LINES_W = 6;

    // game screen encoding
    parameter int SCREEN_W = 2;
    parameter logic [SCREEN_W-1:0] SCREEN_IDLE   = 2'd0;
    parameter logic [SCREEN_W-1:0] SCREEN_SPRINT = 2'd1;
    parameter logic [SCREEN_W-1:0] SCREEN_DONE   = 2'd2;

endpackage

`default_nettype wire

// File: logic/timer_pkg.sv
// sprint timer package
// digit widths and roll-over limits of the time counters
`default_nettype none

package timer_pkg;

    // decimal digits for ms, cs and ds
    parameter int DIGIT_W = 4;
    parameter logic [DIGIT_W-1:0] DIGIT_MAX = 4'd9;

    // seconds and minutes
    parameter int SEXA_W = 6;
    parameter logic [SEXA_W-1:0] SEXA_MAX = 6'd59;

    // hours just wrap
    parameter int HOURS_W = 5;

endpackage

`default_nettype wire
